// File: pong_params.svh
// shared constants for the pong subsystem
// include in any file that needs raster geometry, object sizes or register addresses
`ifndef PONG_PARAMS_SVH
`define PONG_PARAMS_SVH

`define H_RES       64          // active width
`define V_RES       48          // active height
`define H_TOTAL     80          // full line incl. blanking
`define V_TOTAL     56          // full frame incl. blanking
`define HS_START    68          // hsync, active high
`define HS_END      72
`define VS_START    50          // vsync, active high
`define VS_END      52
`define CORDW       8           // coordinate width

`define B_SIZE      4           // ball edge length
`define P_H         12          // paddle height
`define P_W         2           // paddle width
`define P_SP        2           // paddle step per frame
`define P_OFFS      4           // paddle gap to screen edge

`define DEB_LEN     4           // stable cycles before a button level commits
`define SPD_RESET   8'h21       // spx 2, spy 1
`define REG_SPEED   0
`define REG_STATUS  4
`endif

// File: pong_pkg.sv
// types shared by the pong RTL and its testbench
// modules import this package to exchange raster, game and APB bundles
`default_nettype none
`include "pong_params.svh"

package pong_pkg;

    typedef struct packed {
        logic [`CORDW-1:0] x;
        logic [`CORDW-1:0] y;
        logic              hsync;
        logic              vsync;
        logic              de;
    } raster_t;

    typedef struct packed {
        logic [3:0] spx;                // high nibble of the speed byte
        logic [3:0] spy;
    } speed_t;

    typedef struct packed {
        logic              play;
        logic [`CORDW-1:0] bx;
        logic [`CORDW-1:0] by;
        logic [`CORDW-1:0] p1y;
        logic [`CORDW-1:0] p2y;
    } game_t;

    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       de;
        logic [7:0] lum;
    } pixel_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // true when the raster point lies inside a box
    function automatic logic in_box(input raster_t r,
                                    input logic [`CORDW-1:0] left,
                                    input logic [`CORDW-1:0] top,
                                    input logic [`CORDW-1:0] w,
                                    input logic [`CORDW-1:0] h);
        return (r.x >= left) && (r.x < left + w) && (r.y >= top) && (r.y < top + h);
    endfunction

endpackage

`default_nettype wire

// File: display_timings.sv
// raster generator for the shrunken pong screen
// free-running x/y counters, all raster fields leave the same register stage
`default_nettype none
`timescale 1ns/1ps
`include "pong_params.svh"

module display_timings (
    input  wire logic         clk_pix,
    input  wire logic         rst_n,
    output pong_pkg::raster_t raster
);

    logic [`CORDW-1:0] x_nxt;
    logic [`CORDW-1:0] y_nxt;

    always_comb begin
        x_nxt = raster.x + 1'b1;
        y_nxt = raster.y;
        if (raster.x == `H_TOTAL - 1) begin         // end of line
            x_nxt = '0;
            if (raster.y == `V_TOTAL - 1) begin     // end of frame
                y_nxt = '0;
            end else begin
                y_nxt = raster.y + 1'b1;
            end
        end
    end

    // decode syncs and de from the next point so they line up with x/y
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            raster.x     <= '0;
            raster.y     <= '0;
            raster.hsync <= 1'b0;
            raster.vsync <= 1'b0;
            raster.de    <= 1'b1;                   // (0,0) is active
        end else begin
            raster.x     <= x_nxt;
            raster.y     <= y_nxt;
            raster.hsync <= (x_nxt >= `HS_START) && (x_nxt < `HS_END);
            raster.vsync <= (y_nxt >= `VS_START) && (y_nxt < `VS_END);
            raster.de    <= (x_nxt < `H_RES) && (y_nxt < `V_RES);
        end
    end

endmodule

`default_nettype wire

// File: debounce.sv
// button debouncer with two-flop synchronizer
// level follows a stable input, released pulses once on a committed 1 to 0 change
`default_nettype none
`timescale 1ns/1ps
`include "pong_params.svh"

module debounce (
    input  wire logic clk_pix,
    input  wire logic rst_n,
    input  wire logic btn,
    output logic      level,
    output logic      released
);

    logic [1:0]                        sync;    // sync[1] is safe to use
    logic [$clog2(`DEB_LEN + 1)-1:0]   cnt;     // cycles input differs from level

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            sync     <= '0;
            cnt      <= '0;
            level    <= 1'b0;
            released <= 1'b0;
        end else begin
            sync     <= {sync[0], btn};
            released <= 1'b0;
            if (sync[1] == level) begin
                cnt <= '0;                          // bounce, start over
            end else if (cnt == `DEB_LEN - 1) begin
                level    <= sync[1];
                released <= level;                  // old level high means release
                cnt      <= '0;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: pong_game.sv
// pong game logic: idle/play FSM, paddle and ball motion once per frame
// collisions are latched while the frame is scanned and used at the next animate
`default_nettype none
`timescale 1ns/1ps
`include "pong_params.svh"

module pong_game (
    input  wire logic              clk_pix,
    input  wire logic              rst_n,
    input  wire pong_pkg::raster_t raster,
    input  wire logic              move_up,
    input  wire logic              move_dn,
    input  wire logic              toggle,
    input  wire pong_pkg::speed_t  speed,
    output pong_pkg::game_t        game
);
    import pong_pkg::*;

    logic              play;
    logic [`CORDW-1:0] bx, by, p1y, p2y;
    logic              dx, dy;                  // 0 is right / down
    logic [`CORDW-1:0] spx, spy;
    logic              animate, b_draw, p1_draw, p2_draw;
    logic              p1_col, p2_col;

    // step a tracking paddle toward the ball centre
    function automatic logic [`CORDW-1:0] track(input logic [`CORDW-1:0] py,
                                                 input logic [`CORDW-1:0] ball_y);
        logic [`CORDW-1:0] pc;
        logic [`CORDW-1:0] bc;
        pc = py + `CORDW'(`P_H / 2);
        bc = ball_y + `CORDW'(`B_SIZE / 2);
        track = py;
        if (pc + `CORDW'(`P_SP / 2) < bc) begin
            if (py < `V_RES - (`P_H + `P_SP / 2)) track = py + `CORDW'(`P_SP);
        end else if (pc > bc + `CORDW'(`P_SP / 2)) begin
            if (py > `P_SP) track = py - `CORDW'(`P_SP);
        end
    endfunction

    assign animate = (raster.y == `V_RES) && (raster.x == 0);   // start of vblank
    assign spx     = `CORDW'(speed.spx);
    assign spy     = `CORDW'(speed.spy);
    assign b_draw  = in_box(raster, bx, by, `CORDW'(`B_SIZE), `CORDW'(`B_SIZE));
    assign p1_draw = in_box(raster, `CORDW'(`P_OFFS), p1y, `CORDW'(`P_W), `CORDW'(`P_H));
    assign p2_draw = in_box(raster, `CORDW'(`H_RES - `P_OFFS - `P_W), p2y,
                            `CORDW'(`P_W), `CORDW'(`P_H));
    assign game    = '{play: play, bx: bx, by: by, p1y: p1y, p2y: p2y};

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) play <= 1'b0;
        else if (toggle) play <= ~play;
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            p1y <= `CORDW'(18);
            p2y <= `CORDW'(18);
        end else if (animate) begin
            if (play) begin                         // player on paddle 1
                if (move_up && p1y > `P_SP) p1y <= p1y - `CORDW'(`P_SP);
                if (move_dn && p1y < `V_RES - (`P_H + `P_SP)) p1y <= p1y + `CORDW'(`P_SP);
            end else begin
                p1y <= track(p1y, by);
            end
            p2y <= track(p2y, by);
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            p1_col <= 1'b0;
            p2_col <= 1'b0;
        end else if (animate) begin
            p1_col <= 1'b0;
            p2_col <= 1'b0;
        end else if (b_draw) begin
            if (p1_draw) p1_col <= 1'b1;
            if (p2_draw) p2_col <= 1'b1;
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            bx <= `CORDW'(30);
            by <= `CORDW'(20);
            dx <= 1'b0;
            dy <= 1'b0;
        end else if (animate) begin
            if (p1_col || (!p2_col && bx < spx)) begin      // left paddle or edge
                dx <= 1'b0;
                bx <= bx + spx;
            end else if (p2_col || bx >= `H_RES - (spx + `B_SIZE)) begin
                dx <= 1'b1;
                bx <= bx - spx;
            end else bx <= dx ? bx - spx : bx + spx;

            if (by >= `V_RES - (spy + `B_SIZE)) begin        // bottom edge
                dy <= 1'b1;
                by <= by - spy;
            end else if (by < spy) begin                     // top edge
                dy <= 1'b0;
                by <= by + spy;
            end else by <= dy ? by - spy : by + spy;
        end
    end

endmodule

`default_nettype wire

// File: pong_apb_regs.sv
// APB3 register block: ball speed (read/write) and game status (read only)
// zero wait states, pslverr on unknown addresses and on status writes
`default_nettype none
`timescale 1ns/1ps
`include "pong_params.svh"

module pong_apb_regs (
    input  wire logic             clk_pix,
    input  wire logic             rst_n,
    input  wire pong_pkg::apb_req_t apb_req,
    output pong_pkg::apb_rsp_t    apb_rsp,
    input  wire pong_pkg::game_t  game,
    output pong_pkg::speed_t      speed
);

    logic access;
    logic hit_speed, hit_status;

    assign access     = apb_req.psel && apb_req.penable;
    assign hit_speed  = (apb_req.paddr == `REG_SPEED);
    assign hit_status = (apb_req.paddr == `REG_STATUS);

    always_comb begin
        apb_rsp.pready  = 1'b1;                     // never stalls
        apb_rsp.pslverr = access && (!(hit_speed || hit_status)
                                     || (apb_req.pwrite && hit_status));
        if (hit_status) begin
            apb_rsp.prdata = 32'({game.by, game.bx, 7'b0, game.play});
        end else if (hit_speed) begin
            apb_rsp.prdata = 32'(speed);
        end else begin
            apb_rsp.prdata = '0;
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            speed <= `SPD_RESET;
        end else if (access && apb_req.pwrite && hit_speed) begin
            speed <= apb_req.pwdata[7:0];           // spx in high nibble
        end
    end

endmodule

`default_nettype wire

// File: pixel_render.sv
// monochrome renderer: ball and both paddles drawn white on black
// output pixel is the raster delayed by one register stage
`default_nettype none
`timescale 1ns/1ps
`include "pong_params.svh"

module pixel_render (
    input  wire logic              clk_pix,
    input  wire logic              rst_n,
    input  wire pong_pkg::raster_t raster,
    input  wire pong_pkg::game_t   game,
    output pong_pkg::pixel_t       pixel
);
    import pong_pkg::*;

    logic lit;

    always_comb begin
        lit = in_box(raster, game.bx, game.by, `CORDW'(`B_SIZE), `CORDW'(`B_SIZE))
            | in_box(raster, `CORDW'(`P_OFFS), game.p1y, `CORDW'(`P_W), `CORDW'(`P_H))
            | in_box(raster, `CORDW'(`H_RES - `P_OFFS - `P_W), game.p2y,
                     `CORDW'(`P_W), `CORDW'(`P_H));
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            pixel <= '0;
        end else begin
            pixel.hsync <= raster.hsync;
            pixel.vsync <= raster.vsync;
            pixel.de    <= raster.de;
            pixel.lum   <= (raster.de && lit) ? 8'hFF : 8'h00;     // blank outside de
        end
    end

endmodule

`default_nettype wire

// File: pong_top.sv
// pong subsystem top: raster timing, button debounce, game, APB registers, renderer
// clk_pix comes from outside, pixel carries syncs, de and luminance
`default_nettype none
`timescale 1ns/1ps

module pong_top (
    input  wire logic               clk_pix,
    input  wire logic               rst_n,
    input  wire logic               btn_up,
    input  wire logic               btn_dn,
    input  wire logic               btn_ctrl,
    input  wire pong_pkg::apb_req_t apb_req,
    output pong_pkg::apb_rsp_t      apb_rsp,
    output pong_pkg::pixel_t        pixel
);
    import pong_pkg::*;

    raster_t raster;
    game_t   game;
    speed_t  speed;
    logic    move_up, move_dn, sig_ctrl;

    display_timings timings_i (.clk_pix, .rst_n, .raster);

    debounce deb_up_i   (.clk_pix, .rst_n, .btn(btn_up),   .level(move_up), .released());
    debounce deb_dn_i   (.clk_pix, .rst_n, .btn(btn_dn),   .level(move_dn), .released());
    debounce deb_ctrl_i (.clk_pix, .rst_n, .btn(btn_ctrl), .level(),        .released(sig_ctrl));

    pong_game game_i (
        .clk_pix, .rst_n, .raster,
        .move_up, .move_dn,
        .toggle(sig_ctrl),                          // play/idle on release
        .speed, .game
    );

    pong_apb_regs regs_i (.clk_pix, .rst_n, .apb_req, .apb_rsp, .game, .speed);

    pixel_render render_i (.clk_pix, .rst_n, .raster, .game, .pixel);

endmodule

`default_nettype wire

// File: pong_assertions.sv
// bound checker for pong_top covering raster timing, APB responses, ball motion, play state and pixels
// sees only the top ports and keeps small reference models of the expected behavior
`default_nettype none
`timescale 1ns/1ps
`include "pong_params.svh"

module pong_assertions (
    input wire logic               clk_pix,
    input wire logic               rst_n,
    input wire logic               btn_ctrl,
    input wire pong_pkg::apb_req_t apb_req,
    input wire pong_pkg::apb_rsp_t apb_rsp,
    input wire pong_pkg::pixel_t   pixel
);
    import pong_pkg::*;

    localparam int         FRAME    = `H_TOTAL * `V_TOTAL;
    localparam int         HOLD     = `DEB_LEN + 3;         // sync plus stable count
    localparam int         LIT_MAX  = `B_SIZE * `B_SIZE + 2 * `P_W * `P_H;  // ball and both paddles
    localparam int         LIT_MIN  = LIT_MAX - `P_W * `B_SIZE;            // ball over one paddle
    localparam logic [3:0] A_SPEED  = 4'(`REG_SPEED);
    localparam logic [3:0] A_STATUS = 4'(`REG_STATUS);
    localparam logic [7:0] BX_MAX   = 8'(`H_RES - `B_SIZE);
    localparam logic [7:0] BY_MAX   = 8'(`V_RES - `B_SIZE);

    logic        access, rd_status, rd_speed, slv_exp, step_ok, ball_chk;
    logic        hs_prev, de_prev, vs_prev, ctrl_prev, hs_seen, vs_seen, have_read;
    logic        spd_changed, play_exp;
    logic [7:0]  spd_shadow, last_bx, last_by, cur_bx, cur_by, spx, spy;
    int unsigned hs_gap, vs_gap, de_run, lit_cnt, since_read, ctrl_run, ctrl_quiet;
    logic        err_hs = 1'b0, err_vs = 1'b0, err_de = 1'b0, err_slv = 1'b0, err_spd = 1'b0;
    logic        err_ball = 1'b0, err_play = 1'b0, err_lum = 1'b0, err_lit = 1'b0;
    logic        failed;

    assign access    = apb_req.psel && apb_req.penable;
    assign rd_status = access && !apb_req.pwrite && (apb_req.paddr == A_STATUS);
    assign rd_speed  = access && !apb_req.pwrite && (apb_req.paddr == A_SPEED);
    assign slv_exp   = !(apb_req.paddr == A_SPEED || apb_req.paddr == A_STATUS)
                       || (apb_req.pwrite && apb_req.paddr == A_STATUS);
    assign cur_bx    = apb_rsp.prdata[15:8];
    assign cur_by    = apb_rsp.prdata[23:16];
    assign spx       = {4'b0, spd_shadow[7:4]};
    assign spy       = {4'b0, spd_shadow[3:0]};
    assign step_ok   = (cur_bx == 8'(last_bx + spx) || cur_bx == 8'(last_bx - spx))
                       && (cur_by == 8'(last_by + spy) || cur_by == 8'(last_by - spy));
    assign ball_chk  = have_read && !spd_changed && (since_read == FRAME);
    assign failed    = err_hs | err_vs | err_de | err_slv | err_spd | err_ball | err_play
                       | err_lum | err_lit;

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            {hs_prev, de_prev, vs_prev, ctrl_prev, hs_seen, vs_seen, have_read} <= '0;
            {spd_changed, play_exp, last_bx, last_by} <= '0;
            {hs_gap, vs_gap, de_run, lit_cnt, since_read, ctrl_run, ctrl_quiet} <= '0;
            spd_shadow <= `SPD_RESET;
        end else begin
            hs_prev    <= pixel.hsync;
            de_prev    <= pixel.de;
            vs_prev    <= pixel.vsync;
            ctrl_prev  <= btn_ctrl;
            hs_gap     <= (pixel.hsync && !hs_prev) ? 1 : hs_gap + 1;
            hs_seen    <= hs_seen || (pixel.hsync && !hs_prev);
            vs_gap     <= (pixel.vsync && !vs_prev) ? 1 : vs_gap + 1;
            vs_seen    <= vs_seen || (pixel.vsync && !vs_prev);
            de_run     <= pixel.de ? de_run + 1 : 0;
            lit_cnt    <= (pixel.vsync && !vs_prev) ? 0 : lit_cnt + int'(pixel.lum == 8'hFF);
            since_read <= since_read + 1;
            ctrl_run   <= btn_ctrl ? ctrl_run + 1 : 0;
            ctrl_quiet <= (btn_ctrl == ctrl_prev) ? ctrl_quiet + 1 : 0;
            if (!btn_ctrl && ctrl_prev && ctrl_run >= HOLD) play_exp <= ~play_exp;  // release
            if (access && apb_req.pwrite && apb_req.paddr == A_SPEED) begin
                spd_shadow  <= apb_req.pwdata[7:0];
                spd_changed <= 1'b1;
            end else if (rd_status) begin
                last_bx     <= cur_bx;
                last_by     <= cur_by;
                since_read  <= 1;
                have_read   <= 1'b1;
                spd_changed <= 1'b0;
            end
        end
    end

    a_hs_period: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (pixel.hsync && !hs_prev && hs_seen) |-> (hs_gap == `H_TOTAL))
        else begin
            err_hs = 1'b1;
            $error("[ERROR] hsync_period: expected %0d actual %0d", `H_TOTAL, hs_gap);
        end

    a_vs_period: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (pixel.vsync && !vs_prev && vs_seen) |-> (vs_gap == FRAME))
        else begin
            err_vs = 1'b1;
            $error("[ERROR] vsync_period: expected %0d actual %0d", FRAME, vs_gap);
        end

    a_de_run: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (de_prev && !pixel.de) |-> (de_run == `H_RES))
        else begin
            err_de = 1'b1;
            $error("[ERROR] de_run: expected %0d actual %0d", `H_RES, de_run);
        end

    a_apb_slverr: assert property (@(posedge clk_pix) disable iff (!rst_n)
        access |-> (apb_rsp.pready && apb_rsp.pslverr == slv_exp))
        else begin
            err_slv = 1'b1;
            $error("[ERROR] apb_slverr: expected %0b actual %0b", slv_exp, apb_rsp.pslverr);
        end

    a_speed_read: assert property (@(posedge clk_pix) disable iff (!rst_n)
        rd_speed |-> (apb_rsp.prdata == {24'b0, spd_shadow}))
        else begin
            err_spd = 1'b1;
            $error("[ERROR] speed_read: expected %h actual %h", spd_shadow, apb_rsp.prdata);
        end

    // one frame between reads means exactly one motion step per axis
    a_ball: assert property (@(posedge clk_pix) disable iff (!rst_n)
        rd_status |-> (cur_bx <= BX_MAX && cur_by <= BY_MAX && (!ball_chk || step_ok)))
        else begin
            err_ball = 1'b1;
            $error("[ERROR] ball_motion: expected (%0d,%0d) +/- (%0d,%0d) actual (%0d,%0d)",
                   last_bx, last_by, spx, spy, cur_bx, cur_by);
        end

    a_play: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (rd_status && ctrl_quiet >= 2 * HOLD) |-> (apb_rsp.prdata[0] == play_exp))
        else begin
            err_play = 1'b1;
            $error("[ERROR] play_state: expected %0b actual %0b", play_exp, apb_rsp.prdata[0]);
        end

    a_lum_blank: assert property (@(posedge clk_pix) disable iff (!rst_n)
        !pixel.de |-> (pixel.lum == 8'h00))
        else begin
            err_lum = 1'b1;
            $error("[ERROR] lum_blank: expected 00 actual %h", pixel.lum);
        end

    a_lit_count: assert property (@(posedge clk_pix) disable iff (!rst_n)
        (pixel.vsync && !vs_prev) |-> (lit_cnt >= LIT_MIN && lit_cnt <= LIT_MAX))
        else begin
            err_lit = 1'b1;
            $error("[ERROR] lit_pixels: expected %0d..%0d actual %0d", LIT_MIN, LIT_MAX, lit_cnt);
        end

endmodule

`default_nettype wire

// File: tb_pong.sv
// testbench for pong_top: APB accesses, a play/idle toggle and paddle button holds
// checking happens in the bound pong_assertions module, this file drives and ends the run
`default_nettype none
`timescale 1ns/1ps
`include "pong_params.svh"

module tb_pong;
    import pong_pkg::*;

    localparam int FRAME   = `H_TOTAL * `V_TOTAL;
    localparam int TIMEOUT = 14 * FRAME + 1000;         // 12 play frames, setup and margin

    logic       clk_pix = 1'b0;
    logic       rst_n;
    logic       btn_up, btn_dn, btn_ctrl;
    apb_req_t   apb_req;
    apb_rsp_t   apb_rsp;
    pixel_t     pixel;
    logic [7:0] lfsr = 8'd47;
    int         cycles = 0;

    pong_top dut_i (.clk_pix, .rst_n, .btn_up, .btn_dn, .btn_ctrl, .apb_req, .apb_rsp, .pixel);

    bind pong_top pong_assertions assert_i (
        .clk_pix, .rst_n, .btn_ctrl, .apb_req, .apb_rsp, .pixel
    );

    always #5 clk_pix = ~clk_pix;

    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};    // x^8 + x^6 + x^5 + x^4 + 1
    endfunction

    // one LFSR step per bit taken
    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        repeat (n) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
    endtask

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic apb_access(input logic write, input logic [3:0] addr,
                              input logic [31:0] data);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: data};
        @(posedge clk_pix);
        apb_req.penable <= 1'b1;                        // access phase
        @(posedge clk_pix);
        while (!apb_rsp.pready) @(posedge clk_pix);
        apb_req <= '0;
    endtask

    // returns at the same raster phase every frame, just after vsync rises
    task automatic wait_frame();
        @(posedge clk_pix);
        while (pixel.vsync) @(posedge clk_pix);
        while (!pixel.vsync) @(posedge clk_pix);
    endtask

    task automatic press_ctrl();
        logic [7:0] hold;
        take_bits(3, hold);
        btn_ctrl <= 1'b1;
        repeat (`DEB_LEN + 4 + int'(hold)) @(posedge clk_pix);
        btn_ctrl <= 1'b0;
        repeat (4 * (`DEB_LEN + 3)) @(posedge clk_pix);
    endtask

    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        if (dut_i.assert_i.failed) begin
            stop_with_failure("an assertion on pong_top failed, see the error above");
        end else if (cycles > TIMEOUT) begin
            stop_with_failure($sformatf("timeout: no end of test after %0d cycles", cycles));
        end
    end

    initial begin
        logic [7:0] r;
        logic [3:0] spx;
        logic [3:0] spy;
        int         hold;
        rst_n    = 1'b0;
        btn_up   = 1'b0;
        btn_dn   = 1'b0;
        btn_ctrl = 1'b0;
        apb_req  = '0;
        repeat (16) @(posedge clk_pix);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk_pix);

        apb_access(1'b0, 4'(`REG_STATUS), '0);
        apb_access(1'b0, 4'(`REG_SPEED), '0);           // reset speed
        take_bits(2, r);
        spx = 4'(r % 8'd3 + 8'd1);
        take_bits(2, r);
        spy = 4'(r % 8'd3 + 8'd1);
        apb_access(1'b1, 4'(`REG_SPEED), 32'({spx, spy}));
        apb_access(1'b0, 4'(`REG_SPEED), '0);
        apb_access(1'b0, 4'h8, '0);                     // unmapped
        apb_access(1'b1, 4'hC, 32'hFF);
        apb_access(1'b1, 4'(`REG_STATUS), 32'h1);       // read-only register
        press_ctrl();                                   // idle to play

        hold = 0;
        for (int f = 0; f < 12; f++) begin
            wait_frame();
            apb_access(1'b0, 4'(`REG_STATUS), '0);
            if (hold == 0) begin
                take_bits(2, r);
                hold = int'(r) + 1;
                take_bits(1, r);
                btn_up <= r[0];
                btn_dn <= ~r[0];
            end
            hold = hold - 1;
        end
        btn_up <= 1'b0;
        btn_dn <= 1'b0;
        repeat (2 * `H_TOTAL) @(posedge clk_pix);

        if (dut_i.assert_i.failed) begin
            stop_with_failure("an assertion on pong_top failed, see the error above");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
pong_pkg.sv
display_timings.sv
debounce.sv
pong_game.sv
pong_apb_regs.sv
pixel_render.sv
pong_top.sv
pong_assertions.sv
tb_pong.sv

// File: run.sh
#!/bin/sh
# compile and run the pong testbench with Verilator, exit status 0 only on a pass
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --top-module tb_pong -f build.f -o sim_pong
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/sim_pong +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
    exit 0
fi
exit 1
